/* rtl/adv7513_macros.svh */
`ifndef ADV7513_MACROS_SVH
`define ADV7513_MACROS_SVH

// 7-bit I2C address of the HDMI transmitter main map
`define ADV_CHIP_ADDR 7'h39

// register address and register data width
`define ADV_DATA_W 8

// PLL status register and its lock flag
`define ADV_PLL_STATUS_REG 8'h9E
`define ADV_PLL_LOCK_BIT 4

// number of writes in each list
`define ADV_BOOT_LEN 11
`define ADV_INIT_LEN 16

// ORed into register 0x16
// 8'h00 gives 4:4:4 RGB output, 8'h81 gives 4:2:2 YCbCr output
`define ADV_OUTPUT_FMT 8'h00

`endif

/* rtl/adv7513_pkg.sv */
package adv7513_pkg;

    // one register address or one register value
    typedef logic [7:0] reg_byte_t;

    // index into the list of the current stage
    typedef logic [4:0] step_t;

    // sequencer opcodes, one per register list
    typedef enum logic [1:0] {
        stage_boot,
        stage_init,
        stage_pll_check,
        stage_ready
    } stage_t;

    typedef enum logic [1:0] {
        s_issue,
        s_wait,
        s_idle
    } seq_state_t;

    // bus phases of the byte engine
    typedef enum logic [2:0] {
        idle,
        start,
        send_byte,
        ack,
        restart,
        recv_byte,
        master_nack,
        stop
    } i2c_state_t;

endpackage

/* rtl/init_sequencer.sv */
`timescale 1ns/100ps

`include "adv7513_macros.svh"

module init_sequencer import adv7513_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      hdmi_int,
    input  logic      list_end,
    input  logic      busy,
    input  logic      done,
    input  logic      ack_error,
    input  reg_byte_t read_data,
    output stage_t    stage,
    output step_t     step,
    output logic      start,
    output logic      ready
);

    seq_state_t state_q;
    stage_t     stage_q;
    step_t      step_q;
    logic       ready_q;
    logic       int_pending;

    assign stage = stage_q;
    assign step  = step_q;
    assign ready = ready_q;

    // one transaction in flight, issued only to an idle master
    assign start = (state_q == s_issue) && !list_end && !busy;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state_q     <= s_issue;
            stage_q     <= stage_boot;
            step_q      <= '0;
            ready_q     <= 1'b0;
            int_pending <= 1'b0;
        end else begin
            // interrupt is remembered at any time, served only when idle
            if (!hdmi_int) begin
                int_pending <= 1'b1;
            end

            case (state_q)
                s_issue: begin
                    if (list_end) begin
                        step_q <= '0;
                        case (stage_q)
                            stage_boot: stage_q <= stage_init;
                            stage_init: stage_q <= stage_pll_check;
                            default:    stage_q <= stage_boot;
                        endcase
                    end else if (!busy) begin
                        state_q <= s_wait;
                    end
                end

                s_wait: begin
                    if (done) begin
                        state_q <= s_issue;
                        // on a missing acknowledge the same step goes out again
                        if (!ack_error) begin
                            if (stage_q == stage_pll_check) begin
                                if (read_data[`ADV_PLL_LOCK_BIT]) begin
                                    stage_q <= stage_ready;
                                    state_q <= s_idle;
                                    ready_q <= 1'b1;
                                end else begin
                                    // PLL not locked, start over from the bootstrap list
                                    stage_q <= stage_boot;
                                    step_q  <= '0;
                                end
                            end else begin
                                step_q <= step_q + 5'd1;
                            end
                        end
                    end
                end

                s_idle: begin
                    if (int_pending) begin
                        int_pending <= 1'b0;
                        ready_q     <= 1'b0;
                        stage_q     <= stage_boot;
                        step_q      <= '0;
                        state_q     <= s_issue;
                    end
                end

                default: begin
                    state_q <= s_issue;
                end
            endcase
        end
    end

endmodule

/* rtl/reg_table.sv */
`timescale 1ns/100ps

`include "adv7513_macros.svh"

module reg_table import adv7513_pkg::*; (
    input  stage_t    stage,
    input  step_t     step,
    input  reg_byte_t video_reg_17,
    input  reg_byte_t video_reg_3b,
    input  reg_byte_t video_reg_3c,
    output reg_byte_t reg_addr,
    output reg_byte_t reg_value,
    output logic      is_read,
    output logic      list_end
);

    always_comb begin
        {reg_addr, reg_value} = 16'h0000;
        is_read  = 1'b0;
        list_end = 1'b0;

        case (stage)
            stage_boot: begin
                list_end = (step >= 5'(`ADV_BOOT_LEN));
                case (step)
                    // power up all circuits
                    0:  {reg_addr, reg_value} = 16'h41_10;
                    // fixed values from the programming guide
                    1:  {reg_addr, reg_value} = 16'h98_03;
                    2:  {reg_addr, reg_value} = 16'h9A_E0;
                    3:  {reg_addr, reg_value} = 16'h9C_30;
                    4:  {reg_addr, reg_value} = 16'h9D_01;
                    5:  {reg_addr, reg_value} = 16'hA2_A4;
                    6:  {reg_addr, reg_value} = 16'hA3_A4;
                    7:  {reg_addr, reg_value} = 16'hE0_D0;
                    8:  {reg_addr, reg_value} = 16'hF9_00;
                    // enable HPD and monitor sense interrupts, then clear them
                    9:  {reg_addr, reg_value} = 16'h94_C0;
                    10: {reg_addr, reg_value} = 16'h96_C0;
                    default: {reg_addr, reg_value} = 16'h0000;
                endcase
            end

            stage_init: begin
                list_end = (step >= 5'(`ADV_INIT_LEN));
                case (step)
                    0:  {reg_addr, reg_value} = 16'h15_00;
                    1:  {reg_addr, reg_value} = {8'h17, video_reg_17};
                    // 8 bit colour depth plus the selected output format
                    2:  {reg_addr, reg_value} = 16'h16_30 | {8'h00, `ADV_OUTPUT_FMT};
                    3:  {reg_addr, reg_value} = 16'h55_00;
                    4:  {reg_addr, reg_value} = 16'h18_46;
                    // HDMI mode, no HDCP
                    5:  {reg_addr, reg_value} = 16'hAF_06;
                    6:  {reg_addr, reg_value} = 16'hBA_60;
                    // I2S audio, N = 6272 for 44.1 kHz
                    7:  {reg_addr, reg_value} = 16'h0A_00;
                    8:  {reg_addr, reg_value} = 16'h01_00;
                    9:  {reg_addr, reg_value} = 16'h02_18;
                    10: {reg_addr, reg_value} = 16'h03_80;
                    11: {reg_addr, reg_value} = 16'h0B_0E;
                    12: {reg_addr, reg_value} = 16'h0C_05;
                    13: {reg_addr, reg_value} = 16'h0D_10;
                    14: {reg_addr, reg_value} = {8'h3B, video_reg_3b};
                    15: {reg_addr, reg_value} = {8'h3C, video_reg_3c};
                    default: {reg_addr, reg_value} = 16'h0000;
                endcase
            end

            stage_pll_check: begin
                // single read of the PLL status
                reg_addr = `ADV_PLL_STATUS_REG;
                is_read  = 1'b1;
                list_end = (step != 5'd0);
            end

            default: begin
                list_end = 1'b1;
            end
        endcase
    end

endmodule

/* rtl/i2c_master.sv */
`timescale 1ns/100ps

`include "adv7513_macros.svh"

module i2c_master import adv7513_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_byte_t clk_divider,
    input  logic      start,
    input  logic      is_read,
    input  reg_byte_t reg_addr,
    input  reg_byte_t reg_value,
    inout  wire       sda,
    inout  wire       scl,
    output logic      busy,
    output logic      done,
    output logic      ack_error,
    output reg_byte_t read_data
);

    localparam int BIT_W = $clog2(`ADV_DATA_W);

    i2c_state_t       state_q;
    logic [1:0]       phase_q;
    reg_byte_t        div_q;
    logic [BIT_W-1:0] bit_q;
    logic [1:0]       byte_q;
    reg_byte_t        shift_q;
    reg_byte_t        reg_addr_q;
    reg_byte_t        reg_value_q;
    logic             rd_q;
    logic             scl_low_c;
    logic             sda_low_c;
    logic             scl_low_q;
    logic             sda_low_q;
    logic             tick;
    logic             last_phase;
    logic             clk_low_phase;

    // every bit is four phases of (clk_divider + 1) clocks
    assign tick          = (div_q == clk_divider);
    assign last_phase    = tick && (phase_q == 2'd3);
    assign clk_low_phase = (phase_q == 2'd0) || (phase_q == 2'd3);

    // open drain, lines are only pulled low or released
    assign scl = scl_low_q ? 1'b0 : 1'bz;
    assign sda = sda_low_q ? 1'b0 : 1'bz;

    always_comb begin
        scl_low_c = 1'b0;
        sda_low_c = 1'b0;
        case (state_q)
            adv7513_pkg::start: begin
                // sda falls while scl is high in phase 2
                scl_low_c = (phase_q == 2'd3);
                sda_low_c = phase_q[1];
            end
            restart: begin
                scl_low_c = clk_low_phase;
                sda_low_c = phase_q[1];
            end
            send_byte: begin
                scl_low_c = clk_low_phase;
                sda_low_c = !shift_q[`ADV_DATA_W-1];
            end
            ack, recv_byte, master_nack: begin
                scl_low_c = clk_low_phase;
            end
            stop: begin
                // sda rises while scl is high
                scl_low_c = (phase_q == 2'd0);
                sda_low_c = !phase_q[1];
            end
            default: begin
                scl_low_c = 1'b0;
                sda_low_c = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state_q   <= idle;
            phase_q   <= 2'd0;
            div_q     <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
            ack_error <= 1'b0;
            scl_low_q <= 1'b0;
            sda_low_q <= 1'b0;
        end else begin
            done      <= 1'b0;
            scl_low_q <= scl_low_c;
            sda_low_q <= sda_low_c;

            if (state_q == idle || tick) begin
                div_q <= '0;
            end else begin
                div_q <= div_q + 8'd1;
            end
            if (state_q != idle && tick) begin
                phase_q <= phase_q + 2'd1;
            end

            case (state_q)
                idle: begin
                    phase_q <= 2'd0;
                    if (start) begin
                        reg_addr_q  <= reg_addr;
                        reg_value_q <= reg_value;
                        rd_q        <= is_read;
                        shift_q     <= {`ADV_CHIP_ADDR, 1'b0};
                        byte_q      <= 2'd0;
                        busy        <= 1'b1;
                        ack_error   <= 1'b0;
                        state_q     <= adv7513_pkg::start;
                    end
                end

                adv7513_pkg::start, restart: begin
                    if (last_phase) begin
                        bit_q   <= '0;
                        state_q <= send_byte;
                        if (state_q == restart) begin
                            byte_q  <= 2'd2;
                            shift_q <= {`ADV_CHIP_ADDR, 1'b1};
                        end
                    end
                end

                send_byte: begin
                    if (last_phase) begin
                        shift_q <= {shift_q[`ADV_DATA_W-2:0], 1'b0};
                        bit_q   <= bit_q + 1'b1;
                        if (bit_q == BIT_W'(`ADV_DATA_W - 1)) begin
                            state_q <= ack;
                        end
                    end
                end

                ack: begin
                    // slave acknowledge is sampled while scl is high
                    if (tick && phase_q == 2'd2 && sda) begin
                        ack_error <= 1'b1;
                    end
                    if (last_phase) begin
                        bit_q <= '0;
                        if (byte_q == 2'd2) begin
                            state_q <= rd_q ? recv_byte : stop;
                        end else if (rd_q && byte_q == 2'd1) begin
                            state_q <= restart;
                        end else begin
                            byte_q  <= byte_q + 2'd1;
                            shift_q <= (byte_q == 2'd0) ? reg_addr_q : reg_value_q;
                            state_q <= send_byte;
                        end
                    end
                end

                recv_byte: begin
                    if (tick && phase_q == 2'd2) begin
                        shift_q <= {shift_q[`ADV_DATA_W-2:0], sda};
                    end
                    if (last_phase) begin
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == BIT_W'(`ADV_DATA_W - 1)) begin
                            read_data <= shift_q;
                            state_q   <= master_nack;
                        end
                    end
                end

                master_nack: begin
                    if (last_phase) begin
                        state_q <= stop;
                    end
                end

                stop: begin
                    if (last_phase) begin
                        busy    <= 1'b0;
                        done    <= 1'b1;
                        state_q <= idle;
                    end
                end

                default: begin
                    state_q <= idle;
                end
            endcase
        end
    end

endmodule

/* rtl/adv7513_config.sv */
`timescale 1ns/100ps

module adv7513_config import adv7513_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      hdmi_int,
    input  reg_byte_t video_reg_17,
    input  reg_byte_t video_reg_3b,
    input  reg_byte_t video_reg_3c,
    input  reg_byte_t clk_divider,
    inout  wire       sda,
    inout  wire       scl,
    output logic      ready
);

    stage_t    stage;
    step_t     step;
    reg_byte_t reg_addr;
    reg_byte_t reg_value;
    reg_byte_t read_data;
    logic      is_read;
    logic      list_end;
    logic      start;
    logic      busy;
    logic      done;
    logic      ack_error;

    init_sequencer u_init_sequencer (
        .clk       (clk),
        .reset     (reset),
        .hdmi_int  (hdmi_int),
        .list_end  (list_end),
        .busy      (busy),
        .done      (done),
        .ack_error (ack_error),
        .read_data (read_data),
        .stage     (stage),
        .step      (step),
        .start     (start),
        .ready     (ready)
    );

    reg_table u_reg_table (
        .stage        (stage),
        .step         (step),
        .video_reg_17 (video_reg_17),
        .video_reg_3b (video_reg_3b),
        .video_reg_3c (video_reg_3c),
        .reg_addr     (reg_addr),
        .reg_value    (reg_value),
        .is_read      (is_read),
        .list_end     (list_end)
    );

    i2c_master u_i2c_master (
        .clk         (clk),
        .reset       (reset),
        .clk_divider (clk_divider),
        .start       (start),
        .is_read     (is_read),
        .reg_addr    (reg_addr),
        .reg_value   (reg_value),
        .sda         (sda),
        .scl         (scl),
        .busy        (busy),
        .done        (done),
        .ack_error   (ack_error),
        .read_data   (read_data)
    );

endmodule

/* verification/adv7513_assertions.sv */
`timescale 1ns/100ps

module adv7513_assertions import adv7513_pkg::*; (
    input logic   clk,
    input logic   reset,
    input logic   start,
    input logic   busy,
    input logic   done,
    input logic   ready,
    input stage_t stage
);

    // the master takes every start at once and is busy on the next cycle
    assert property (@(posedge clk) disable iff (!reset) start |=> busy)
        else $error("busy did not follow a start of the I2C master");

    assert property (@(posedge clk) disable iff (!reset) ready |-> stage == stage_ready)
        else $error("ready is high outside the ready stage");

    // done closes a transaction that was in flight
    assert property (@(posedge clk) disable iff (!reset) done |-> $past(busy))
        else $error("done pulsed without a transaction in flight");

endmodule

// busy and done of the I2C master arrive here as sequencer inputs
bind init_sequencer adv7513_assertions u_adv7513_assertions (.*);

/* verification/i2c_slave_model.sv */
`timescale 1ns/100ps

`include "adv7513_macros.svh"

module i2c_slave_model import adv7513_pkg::*; (
    inout  wire        sda,
    inout  wire        scl,
    input  logic       clear,
    input  logic [1:0] pll_fail_count,
    input  logic       nack_on,
    input  reg_byte_t  nack_reg
);

    localparam int LOG_DEPTH = 256;

    // register and value of every write seen on the bus
    reg_byte_t log_addr [0:LOG_DEPTH-1];
    reg_byte_t log_val  [0:LOG_DEPTH-1];
    int        log_count = 0;

    logic      sda_low   = 1'b0;
    logic      sda_q     = 1'b1;
    logic      scl_q     = 1'b1;
    logic      in_frame  = 1'b0;
    logic      rw        = 1'b0;
    logic      sending   = 1'b0;
    logic      nack_used = 1'b0;
    int        bit_cnt   = 0;
    int        byte_idx  = 0;
    int        pll_reads = 0;
    reg_byte_t shift     = 8'h00;
    reg_byte_t reg_ptr   = 8'h00;
    reg_byte_t tx_byte   = 8'h00;

    // scl is never held low, no clock stretching
    assign sda = sda_low ? 1'b0 : 1'bz;

    task clear_state();
        log_count = 0;
        pll_reads = 0;
        nack_used = 1'b0;
        in_frame  = 1'b0;
        sending   = 1'b0;
        sda_low   = 1'b0;
        bit_cnt   = 0;
        byte_idx  = 0;
    endtask

    task load_read_byte();
        if (reg_ptr == `ADV_PLL_STATUS_REG) begin
            // lock flag sits in bit 4, reported only after the programmed failures
            tx_byte = (pll_reads < pll_fail_count) ? 8'h00 : 8'h10;
            pll_reads++;
        end else begin
            tx_byte = 8'h00;
        end
    endtask

    task take_byte();
        case (byte_idx)
            0: begin
                rw = shift[0];
                if (shift[7:1] == `ADV_CHIP_ADDR) begin
                    sda_low = 1'b1;
                end else begin
                    in_frame = 1'b0;
                end
            end
            1: begin
                reg_ptr = shift;
                sda_low = 1'b1;
            end
            default: begin
                if (log_count < LOG_DEPTH) begin
                    log_addr[log_count] = reg_ptr;
                    log_val[log_count]  = shift;
                end
                log_count++;
                // refuse the chosen register once per run
                if (nack_on && !nack_used && reg_ptr == nack_reg) begin
                    nack_used = 1'b1;
                end else begin
                    sda_low = 1'b1;
                end
            end
        endcase
        byte_idx++;
    endtask

    task scl_rise();
        if (bit_cnt < 8) begin
            shift = {shift[6:0], (sda === 1'b0) ? 1'b0 : 1'b1};
        end
        bit_cnt++;
    endtask

    task scl_fall();
        if (bit_cnt == 8) begin
            sda_low = 1'b0;
            if (!sending) begin
                take_byte();
            end
        end else if (bit_cnt >= 9) begin
            bit_cnt = 0;
            sda_low = 1'b0;
            if (sending) begin
                sending = 1'b0;
            end else if (rw && byte_idx == 1) begin
                load_read_byte();
                sending = 1'b1;
                sda_low = !tx_byte[7];
            end
        end else if (sending) begin
            sda_low = !tx_byte[7 - bit_cnt];
        end
    endtask

    // all bus events in one place, edges found from the previous line levels
    always @(sda or scl or clear) begin
        if (clear) begin
            clear_state();
        end else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
            // start or repeated start
            in_frame = 1'b1;
            bit_cnt  = 0;
            byte_idx = 0;
            sending  = 1'b0;
        end else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
            in_frame = 1'b0;
        end else if (in_frame && scl === 1'b1 && scl_q !== 1'b1) begin
            scl_rise();
        end else if (in_frame && scl === 1'b0 && scl_q === 1'b1) begin
            scl_fall();
        end
        sda_q = sda;
        scl_q = scl;
    end

endmodule

/* verification/tb_adv7513_config.sv */
`timescale 1ns/100ps

`include "adv7513_macros.svh"

module tb_adv7513_config import adv7513_pkg::*; ();

    localparam int NUM_ROWS       = 6;
    localparam int TIMEOUT_CYCLES = 250000;
    localparam int INT_TIMEOUT    = 20;

    typedef struct packed {
        reg_byte_t  v17;
        reg_byte_t  v3b;
        reg_byte_t  v3c;
        logic [1:0] pll_fail;
        logic       nack_on;
        reg_byte_t  nack_reg;
        logic       pulse_int;
        logic [2:0] passes;
    } row_t;

    logic       clk;
    logic       reset;
    logic       hdmi_int;
    reg_byte_t  video_reg_17;
    reg_byte_t  video_reg_3b;
    reg_byte_t  video_reg_3c;
    reg_byte_t  clk_divider;
    wire        sda;
    wire        scl;
    logic       ready;
    logic       clear;
    logic [1:0] pll_fail_count;
    logic       nack_on;
    reg_byte_t  nack_reg;

    row_t        rows [0:NUM_ROWS-1];
    logic [15:0] exp_list [$];
    int          tests  = 0;
    int          checks = 0;
    int          errors = 0;

    // bootstrap writes as {register, value}
    logic [15:0] boot_list [0:10] = '{
        16'h4110, 16'h9803, 16'h9AE0, 16'h9C30, 16'h9D01, 16'hA2A4,
        16'hA3A4, 16'hE0D0, 16'hF900, 16'h94C0, 16'h96C0
    };

    // init writes, video values at 0x17, 0x3B and 0x3C come from the row
    logic [15:0] init_list [0:15] = '{
        16'h1500, 16'h1700, 16'h1630, 16'h5500, 16'h1846, 16'hAF06, 16'hBA60, 16'h0A00,
        16'h0100, 16'h0218, 16'h0380, 16'h0B0E, 16'h0C05, 16'h0D10, 16'h3B00, 16'h3C00
    };

    adv7513_config u_adv7513_config (
        .clk          (clk),
        .reset        (reset),
        .hdmi_int     (hdmi_int),
        .video_reg_17 (video_reg_17),
        .video_reg_3b (video_reg_3b),
        .video_reg_3c (video_reg_3c),
        .clk_divider  (clk_divider),
        .sda          (sda),
        .scl          (scl),
        .ready        (ready)
    );

    i2c_slave_model u_i2c_slave_model (
        .sda            (sda),
        .scl            (scl),
        .clear          (clear),
        .pll_fail_count (pll_fail_count),
        .nack_on        (nack_on),
        .nack_reg       (nack_reg)
    );

    pullup (sda);
    pullup (scl);

    always #50 clk = ~clk;

    task automatic check_byte(input reg_byte_t got, input reg_byte_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0d ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0d ns: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic wait_ready(input logic level, input int limit, output logic ok);
        int cycles;
        cycles = 0;
        while (ready !== level && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        ok = (ready === level);
        if (!ok) begin
            errors++;
            $display("timeout: ready did not go %s within %0d clock cycles",
                     level ? "high" : "low", limit);
        end
    endtask

    function automatic logic [15:0] init_entry(input int k, input row_t row);
        case (k)
            1:       init_entry = {8'h17, row.v17};
            2:       init_entry = init_list[2] | {8'h00, `ADV_OUTPUT_FMT};
            14:      init_entry = {8'h3B, row.v3b};
            15:      init_entry = {8'h3C, row.v3c};
            default: init_entry = init_list[k];
        endcase
    endfunction

    task automatic build_expected(input row_t row);
        logic        nack_left;
        logic [15:0] entry;
        exp_list.delete();
        nack_left = row.nack_on;
        for (int p = 0; p < row.passes; p++) begin
            for (int k = 0; k < 27; k++) begin
                entry = (k < 11) ? boot_list[k] : init_entry(k - 11, row);
                exp_list.push_back(entry);
                // a refused write goes out again right away
                if (nack_left && entry[15:8] == row.nack_reg) begin
                    exp_list.push_back(entry);
                    nack_left = 1'b0;
                end
            end
        end
    endtask

    task automatic compare_log();
        int n;
        n = u_i2c_slave_model.log_count;
        check_level(n == exp_list.size(), 1'b1,
                    $sformatf("write log length (%0d logged, %0d expected)", n, exp_list.size()));
        if (n > exp_list.size()) begin
            n = exp_list.size();
        end
        for (int i = 0; i < n; i++) begin
            check_byte(u_i2c_slave_model.log_addr[i], exp_list[i][15:8],
                       $sformatf("register of write %0d", i));
            check_byte(u_i2c_slave_model.log_val[i], exp_list[i][7:0],
                       $sformatf("value of write %0d", i));
        end
    endtask

    task automatic run_test(input int idx, input row_t row);
        logic ok;
        int   errors_before;
        errors_before = errors;
        @(negedge clk);
        reset          = 1'b0;
        clear          = 1'b1;
        video_reg_17   = row.v17;
        video_reg_3b   = row.v3b;
        video_reg_3c   = row.v3c;
        clk_divider    = 8'($urandom_range(4, 1));
        pll_fail_count = row.pll_fail;
        nack_on        = row.nack_on;
        nack_reg       = row.nack_reg;
        repeat (16) @(negedge clk);
        reset = 1'b1;
        clear = 1'b0;
        check_level(ready, 1'b0, "ready right after reset");
        wait_ready(1'b1, TIMEOUT_CYCLES, ok);
        if (ok && row.pulse_int) begin
            @(negedge clk);
            hdmi_int = 1'b0;
            @(negedge clk);
            hdmi_int = 1'b1;
            wait_ready(1'b0, INT_TIMEOUT, ok);
            if (ok) begin
                wait_ready(1'b1, TIMEOUT_CYCLES, ok);
            end
        end
        if (ok) begin
            build_expected(row);
            compare_log();
        end
        tests++;
        $display("test %0d: divider %0d, %0d writes logged, %0d errors", idx, clk_divider,
                 u_i2c_slave_model.log_count, errors - errors_before);
    endtask

    initial begin
        int unsigned seed;
        clk            = 1'b0;
        reset          = 1'b0;
        hdmi_int       = 1'b1;
        video_reg_17   = 8'h00;
        video_reg_3b   = 8'h00;
        video_reg_3c   = 8'h00;
        clk_divider    = 8'd1;
        clear          = 1'b0;
        pll_fail_count = 2'd0;
        nack_on        = 1'b0;
        nack_reg       = 8'h00;
        seed           = 32'ha5df;
        seed           = $urandom(seed);

        // video_reg_17, video_reg_3b, video_reg_3c, PLL failures, NACK on, NACK register,
        // interrupt pulse, expected passes through boot plus init
        rows[0] = {8'h02, 8'h80, 8'h10, 2'd0, 1'b0, 8'h00, 1'b0, 3'd1};
        rows[1] = {8'h00, 8'h81, 8'h04, 2'd2, 1'b0, 8'h00, 1'b0, 3'd3};
        rows[2] = {8'h02, 8'h80, 8'h10, 2'd0, 1'b1, 8'h9D, 1'b0, 3'd1};
        rows[3] = {8'h00, 8'hC0, 8'h1F, 2'd1, 1'b1, 8'hAF, 1'b0, 3'd2};
        rows[4] = {8'h02, 8'h3A, 8'h65, 2'd0, 1'b0, 8'h00, 1'b1, 3'd2};
        rows[5] = {8'h00, 8'h80, 8'h10, 2'd0, 1'b1, 8'h3C, 1'b1, 3'd2};

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_test(r, rows[r]);
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+rtl
rtl/adv7513_pkg.sv
rtl/init_sequencer.sv
rtl/reg_table.sv
rtl/i2c_master.sv
rtl/adv7513_config.sv
verification/adv7513_assertions.sv
verification/i2c_slave_model.sv
verification/tb_adv7513_config.sv
